// File: include/rv32_ctrl_consts.svh
`ifndef RV32_CTRL_CONSTS_SVH
`define RV32_CTRL_CONSTS_SVH

// RV32I base opcodes
`define RV_OP_LUI     7'b0110111
`define RV_OP_AUIPC   7'b0010111
`define RV_OP_JAL     7'b1101111
`define RV_OP_JALR    7'b1100111
`define RV_OP_BR      7'b1100011
`define RV_OP_LOAD    7'b0000011
`define RV_OP_STORE   7'b0100011
`define RV_OP_IMM     7'b0010011
`define RV_OP_REG     7'b0110011
`define RV_OP_NONE    7'b0000000

// Load and store widths
`define RV_F3_BYTE    3'b000
`define RV_F3_HALF    3'b001
`define RV_F3_WORD    3'b010
`define RV_F3_BYTE_U  3'b100
`define RV_F3_HALF_U  3'b101

// Register and immediate ALU ops
`define RV_F3_ADD     3'b000
`define RV_F3_SLL     3'b001
`define RV_F3_SLT     3'b010
`define RV_F3_SLTU    3'b011
`define RV_F3_XOR     3'b100
`define RV_F3_SR      3'b101
`define RV_F3_OR      3'b110
`define RV_F3_AND     3'b111

`define RV_REG_W      5
`define RV_BE_W       4

`endif

// File: rtl/rv32_ctrl_pkg.sv
`include "rv32_ctrl_consts.svh"

package rv32_ctrl_pkg;

    typedef enum logic [6:0] {
        op_lui   = `RV_OP_LUI,
        op_auipc = `RV_OP_AUIPC,
        op_jal   = `RV_OP_JAL,
        op_jalr  = `RV_OP_JALR,
        op_br    = `RV_OP_BR,
        op_load  = `RV_OP_LOAD,
        op_store = `RV_OP_STORE,
        op_imm   = `RV_OP_IMM,
        op_reg   = `RV_OP_REG,
        op_none  = `RV_OP_NONE
    } opcode_t;

    typedef enum logic [2:0] {
        alu_add = 3'b000,
        alu_sll = 3'b001,
        alu_sra = 3'b010,
        alu_sub = 3'b011,
        alu_xor = 3'b100,
        alu_srl = 3'b101,
        alu_or  = 3'b110,
        alu_and = 3'b111
    } alu_op_t;

    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } branch_funct3_t;

    typedef enum logic {
        alumux1_rs1 = 1'b0,
        alumux1_pc  = 1'b1
    } alumux1_sel_t;

    typedef enum logic [2:0] {
        alumux2_i_imm = 3'd0,
        alumux2_u_imm = 3'd1,
        alumux2_b_imm = 3'd2,
        alumux2_s_imm = 3'd3,
        alumux2_j_imm = 3'd4,
        alumux2_rs2   = 3'd5
    } alumux2_sel_t;

    typedef enum logic {
        cmpmux_rs2   = 1'b0,
        cmpmux_i_imm = 1'b1
    } cmpmux_sel_t;

    typedef enum logic [1:0] {
        pc_plus4       = 2'd0,
        pcmux_alu_out  = 2'd1,
        pcmux_alu_mod2 = 2'd2
    } pcmux_sel_t;

    typedef enum logic [3:0] {
        regfilemux_alu_out  = 4'd0,
        regfilemux_br_en    = 4'd1,
        regfilemux_u_imm    = 4'd2,
        regfilemux_lw       = 4'd3,
        regfilemux_pc_plus4 = 4'd4,
        regfilemux_lb       = 4'd5,
        regfilemux_lbu      = 4'd6,
        regfilemux_lh       = 4'd7,
        regfilemux_lhu      = 4'd8
    } regfilemux_sel_t;

    typedef struct packed {
        logic [6:0]           funct7;
        logic [`RV_REG_W-1:0] rs2;
        logic [`RV_REG_W-1:0] rs1;
        logic [2:0]           funct3;
        logic [`RV_REG_W-1:0] rd;
        logic [6:0]           opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]          imm_11_0;
        logic [`RV_REG_W-1:0] rs1;
        logic [2:0]           funct3;
        logic [`RV_REG_W-1:0] rd;
        logic [6:0]           opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]           imm_11_5;
        logic [`RV_REG_W-1:0] rs2;
        logic [`RV_REG_W-1:0] rs1;
        logic [2:0]           funct3;
        logic [4:0]           imm_4_0;
        logic [6:0]           opcode;
    } s_fmt_t;

    typedef struct packed {
        logic                 imm_12;
        logic [5:0]           imm_10_5;
        logic [`RV_REG_W-1:0] rs2;
        logic [`RV_REG_W-1:0] rs1;
        logic [2:0]           funct3;
        logic [3:0]           imm_4_1;
        logic                 imm_11;
        logic [6:0]           opcode;
    } b_fmt_t;

    // One instruction word, four ways to read it
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
    } instr_word_u;

    typedef struct packed {
        opcode_t              opcode;
        alumux1_sel_t         alumux1_sel;
        alumux2_sel_t         alumux2_sel;
        cmpmux_sel_t          cmpmux_sel;
        alu_op_t              alu_op;
        branch_funct3_t       cmp_op;
        pcmux_sel_t           pcmux_sel;
        logic                 d_read;
        logic                 d_write;
        logic [`RV_BE_W-1:0]  d_byte_enable;
        regfilemux_sel_t      regfilemux_sel;
        logic                 regfile_wb;
        logic [`RV_REG_W-1:0] regfile_rd;
    } ctrl_word_t;

    parameter ctrl_word_t CTRL_BUBBLE = '{
        opcode:         op_none,
        alumux1_sel:    alumux1_rs1,
        alumux2_sel:    alumux2_i_imm,
        cmpmux_sel:     cmpmux_rs2,
        alu_op:         alu_add,
        cmp_op:         beq,
        pcmux_sel:      pc_plus4,
        d_read:         1'b0,
        d_write:        1'b0,
        d_byte_enable:  '0,
        regfilemux_sel: regfilemux_alu_out,
        regfile_wb:     1'b0,
        regfile_rd:     '0
    };

endpackage

// File: rtl/ctrl_decoder.sv
`include "rv32_ctrl_consts.svh"

module ctrl_decoder (
    input  rv32_ctrl_pkg::instr_word_u instr,
    output rv32_ctrl_pkg::ctrl_word_t  ctrl
);

    // Access width from funct3, zero for an unknown width
    function automatic logic [`RV_BE_W-1:0] be_from_funct3(input logic [2:0] f3);
        case (f3)
            `RV_F3_BYTE, `RV_F3_BYTE_U: be_from_funct3 = 4'b0001;
            `RV_F3_HALF, `RV_F3_HALF_U: be_from_funct3 = 4'b0011;
            `RV_F3_WORD:                be_from_funct3 = 4'b1111;
            default:                    be_from_funct3 = 4'b0000;
        endcase
    endfunction

    always_comb begin
        ctrl = rv32_ctrl_pkg::CTRL_BUBBLE;
        case (instr.r.opcode)
            `RV_OP_LUI: begin
                ctrl.opcode         = rv32_ctrl_pkg::op_lui;
                ctrl.regfilemux_sel = rv32_ctrl_pkg::regfilemux_u_imm;
                ctrl.regfile_wb     = 1'b1;
                ctrl.regfile_rd     = instr.r.rd;
            end
            `RV_OP_AUIPC: begin
                ctrl.opcode      = rv32_ctrl_pkg::op_auipc;
                ctrl.alumux1_sel = rv32_ctrl_pkg::alumux1_pc;
                ctrl.alumux2_sel = rv32_ctrl_pkg::alumux2_u_imm;
                ctrl.regfile_wb  = 1'b1;
                ctrl.regfile_rd  = instr.r.rd;
            end
            `RV_OP_JAL: begin
                ctrl.opcode         = rv32_ctrl_pkg::op_jal;
                ctrl.alumux1_sel    = rv32_ctrl_pkg::alumux1_pc;
                ctrl.alumux2_sel    = rv32_ctrl_pkg::alumux2_j_imm;
                ctrl.pcmux_sel      = rv32_ctrl_pkg::pcmux_alu_out;
                ctrl.regfilemux_sel = rv32_ctrl_pkg::regfilemux_pc_plus4;
                ctrl.regfile_wb     = 1'b1;
                ctrl.regfile_rd     = instr.r.rd;
            end
            `RV_OP_JALR: begin
                ctrl.opcode         = rv32_ctrl_pkg::op_jalr;
                ctrl.pcmux_sel      = rv32_ctrl_pkg::pcmux_alu_mod2;
                ctrl.regfilemux_sel = rv32_ctrl_pkg::regfilemux_pc_plus4;
                ctrl.regfile_wb     = 1'b1;
                ctrl.regfile_rd     = instr.i.rd;
            end
            `RV_OP_BR: begin
                // Target from the ALU, the datapath takes it only on br_en
                ctrl.opcode      = rv32_ctrl_pkg::op_br;
                ctrl.alumux1_sel = rv32_ctrl_pkg::alumux1_pc;
                ctrl.alumux2_sel = rv32_ctrl_pkg::alumux2_b_imm;
                ctrl.cmp_op      = rv32_ctrl_pkg::branch_funct3_t'(instr.b.funct3);
                ctrl.pcmux_sel   = rv32_ctrl_pkg::pcmux_alu_out;
            end
            `RV_OP_LOAD: begin
                ctrl.opcode        = rv32_ctrl_pkg::op_load;
                ctrl.d_read        = 1'b1;
                ctrl.d_byte_enable = be_from_funct3(instr.i.funct3);
                ctrl.regfile_wb    = 1'b1;
                ctrl.regfile_rd    = instr.i.rd;
                case (instr.i.funct3)
                    `RV_F3_BYTE:   ctrl.regfilemux_sel = rv32_ctrl_pkg::regfilemux_lb;
                    `RV_F3_HALF:   ctrl.regfilemux_sel = rv32_ctrl_pkg::regfilemux_lh;
                    `RV_F3_WORD:   ctrl.regfilemux_sel = rv32_ctrl_pkg::regfilemux_lw;
                    `RV_F3_BYTE_U: ctrl.regfilemux_sel = rv32_ctrl_pkg::regfilemux_lbu;
                    `RV_F3_HALF_U: ctrl.regfilemux_sel = rv32_ctrl_pkg::regfilemux_lhu;
                    default:       ctrl = rv32_ctrl_pkg::CTRL_BUBBLE;
                endcase
            end
            `RV_OP_STORE: begin
                ctrl.opcode        = rv32_ctrl_pkg::op_store;
                ctrl.alumux2_sel   = rv32_ctrl_pkg::alumux2_s_imm;
                ctrl.d_write       = 1'b1;
                ctrl.d_byte_enable = be_from_funct3(instr.s.funct3);
                // No unsigned stores
                if (instr.s.funct3[2] || ctrl.d_byte_enable == '0) begin
                    ctrl = rv32_ctrl_pkg::CTRL_BUBBLE;
                end
            end
            `RV_OP_IMM, `RV_OP_REG: begin
                ctrl.regfile_wb = 1'b1;
                ctrl.regfile_rd = instr.r.rd;
                if (instr.r.opcode == `RV_OP_REG) begin
                    ctrl.opcode      = rv32_ctrl_pkg::op_reg;
                    ctrl.alumux2_sel = rv32_ctrl_pkg::alumux2_rs2;
                end else begin
                    ctrl.opcode     = rv32_ctrl_pkg::op_imm;
                    ctrl.cmpmux_sel = rv32_ctrl_pkg::cmpmux_i_imm;
                end
                case (instr.r.funct3)
                    `RV_F3_ADD: begin
                        // SUB only exists in register form
                        if (instr.r.opcode == `RV_OP_REG && instr.r.funct7[5]) begin
                            ctrl.alu_op = rv32_ctrl_pkg::alu_sub;
                        end
                    end
                    `RV_F3_SLL: ctrl.alu_op = rv32_ctrl_pkg::alu_sll;
                    `RV_F3_SLT: begin
                        ctrl.cmp_op         = rv32_ctrl_pkg::blt;
                        ctrl.regfilemux_sel = rv32_ctrl_pkg::regfilemux_br_en;
                    end
                    `RV_F3_SLTU: begin
                        ctrl.cmp_op         = rv32_ctrl_pkg::bltu;
                        ctrl.regfilemux_sel = rv32_ctrl_pkg::regfilemux_br_en;
                    end
                    `RV_F3_XOR: ctrl.alu_op = rv32_ctrl_pkg::alu_xor;
                    `RV_F3_SR: begin
                        if (instr.r.funct7[5]) begin
                            ctrl.alu_op = rv32_ctrl_pkg::alu_sra;
                        end else begin
                            ctrl.alu_op = rv32_ctrl_pkg::alu_srl;
                        end
                    end
                    `RV_F3_OR:  ctrl.alu_op = rv32_ctrl_pkg::alu_or;
                    `RV_F3_AND: ctrl.alu_op = rv32_ctrl_pkg::alu_and;
                endcase
            end
            default: ctrl = rv32_ctrl_pkg::CTRL_BUBBLE;
        endcase
    end

endmodule

// File: rtl/ctrl_word_pipe.sv
module ctrl_word_pipe (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      stall,
    input  logic                      redirect,
    input  rv32_ctrl_pkg::ctrl_word_t new_word,
    output rv32_ctrl_pkg::ctrl_word_t if_id,
    output rv32_ctrl_pkg::ctrl_word_t id_ex,
    output rv32_ctrl_pkg::ctrl_word_t ex_mem,
    output rv32_ctrl_pkg::ctrl_word_t mem_wb
);

    rv32_ctrl_pkg::ctrl_word_t if_id_next;
    rv32_ctrl_pkg::ctrl_word_t id_ex_next;

    // A taken branch kills the two words fetched behind it
    always_comb begin
        if (redirect) begin
            if_id_next = rv32_ctrl_pkg::CTRL_BUBBLE;
            id_ex_next = rv32_ctrl_pkg::CTRL_BUBBLE;
        end else begin
            if_id_next = new_word;
            id_ex_next = if_id;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            if_id  <= rv32_ctrl_pkg::CTRL_BUBBLE;
            id_ex  <= rv32_ctrl_pkg::CTRL_BUBBLE;
            ex_mem <= rv32_ctrl_pkg::CTRL_BUBBLE;
            mem_wb <= rv32_ctrl_pkg::CTRL_BUBBLE;
        end else if (!stall) begin
            if_id  <= if_id_next;
            id_ex  <= id_ex_next;
            ex_mem <= id_ex;
            mem_wb <= ex_mem;
        end
    end

endmodule

// File: rtl/dmem_wb_master.sv
module dmem_wb_master (
    input  logic                      clk,
    input  logic                      rst,
    input  rv32_ctrl_pkg::ctrl_word_t ex_mem,
    input  logic [31:0]               mem_addr,
    input  logic [31:0]               mem_wdata,
    output logic                      wb_cyc,
    output logic                      wb_stb,
    output logic                      wb_we,
    output logic [3:0]                wb_sel,
    output logic [31:0]               wb_adr,
    output logic [31:0]               wb_dat_o,
    input  logic [31:0]               wb_dat_i,
    input  logic                      wb_ack,
    output logic                      mem_busy,
    output logic [31:0]               mem_rdata,
    output logic                      mem_rdata_valid
);

    rv32_ctrl_pkg::ctrl_word_t ex_mem_q;
    logic                      pending;
    logic                      word_changed;
    logic                      done;
    logic                      done_eff;

    assign pending      = ex_mem.d_read | ex_mem.d_write;
    assign word_changed = (ex_mem != ex_mem_q);
    // Old done flag belongs to the previous word
    assign done_eff     = done & ~word_changed;

    assign wb_cyc   = pending & ~done_eff;
    assign wb_stb   = wb_cyc;
    assign wb_we    = ex_mem.d_write;
    assign wb_sel   = ex_mem.d_byte_enable;
    assign wb_adr   = mem_addr;
    assign wb_dat_o = mem_wdata;

    assign mem_busy = wb_cyc & ~wb_ack;

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_mem_q        <= rv32_ctrl_pkg::CTRL_BUBBLE;
            done            <= 1'b0;
            mem_rdata_valid <= 1'b0;
        end else begin
            ex_mem_q        <= ex_mem;
            done            <= done_eff | (wb_cyc & wb_ack);
            mem_rdata_valid <= wb_cyc & wb_ack & ex_mem.d_read;
        end
    end

    always_ff @(posedge clk) begin
        if (wb_cyc && wb_ack && ex_mem.d_read) begin
            mem_rdata <= wb_dat_i;
        end
    end

endmodule

// File: rtl/ctrl_path_top.sv
`include "rv32_ctrl_consts.svh"

module ctrl_path_top (
    input  logic                           clk,
    input  logic                           rst,
    input  rv32_ctrl_pkg::instr_word_u     instr,
    input  logic                           instr_valid,
    input  logic                           redirect,
    input  logic [31:0]                    mem_addr,
    input  logic [31:0]                    mem_wdata,

    // IF/ID
    output rv32_ctrl_pkg::cmpmux_sel_t     cmpmux_sel,
    output rv32_ctrl_pkg::alumux1_sel_t    alumux1_sel,
    output rv32_ctrl_pkg::alumux2_sel_t    alumux2_sel,
    // ID/EX
    output rv32_ctrl_pkg::alu_op_t         alu_op,
    output rv32_ctrl_pkg::branch_funct3_t  cmp_op,
    output rv32_ctrl_pkg::pcmux_sel_t      pcmux_sel,
    // EX/MEM
    output rv32_ctrl_pkg::regfilemux_sel_t regfilemux_sel,
    // MEM/WB
    output logic                           regfile_wb,
    output logic [`RV_REG_W-1:0]           regfile_rd,

    output logic                           stall,
    output logic [31:0]                    mem_rdata,
    output logic                           mem_rdata_valid,

    output logic                           wb_cyc,
    output logic                           wb_stb,
    output logic                           wb_we,
    output logic [`RV_BE_W-1:0]            wb_sel,
    output logic [31:0]                    wb_adr,
    output logic [31:0]                    wb_dat_o,
    input  logic [31:0]                    wb_dat_i,
    input  logic                           wb_ack
);

    rv32_ctrl_pkg::ctrl_word_t new_word;
    rv32_ctrl_pkg::ctrl_word_t if_id;
    rv32_ctrl_pkg::ctrl_word_t id_ex;
    rv32_ctrl_pkg::ctrl_word_t ex_mem;
    rv32_ctrl_pkg::ctrl_word_t mem_wb;
    logic                      mem_busy;

    assign stall = ~instr_valid | mem_busy;

    assign cmpmux_sel     = if_id.cmpmux_sel;
    assign alumux1_sel    = if_id.alumux1_sel;
    assign alumux2_sel    = if_id.alumux2_sel;
    assign alu_op         = id_ex.alu_op;
    assign cmp_op         = id_ex.cmp_op;
    assign pcmux_sel      = id_ex.pcmux_sel;
    assign regfilemux_sel = ex_mem.regfilemux_sel;
    assign regfile_wb     = mem_wb.regfile_wb;
    assign regfile_rd     = mem_wb.regfile_rd;

    ctrl_decoder u_decoder (
        .instr (instr),
        .ctrl  (new_word)
    );

    ctrl_word_pipe u_pipe (
        .clk      (clk),
        .rst      (rst),
        .stall    (stall),
        .redirect (redirect),
        .new_word (new_word),
        .if_id    (if_id),
        .id_ex    (id_ex),
        .ex_mem   (ex_mem),
        .mem_wb   (mem_wb)
    );

    dmem_wb_master u_dmem (
        .clk             (clk),
        .rst             (rst),
        .ex_mem          (ex_mem),
        .mem_addr        (mem_addr),
        .mem_wdata       (mem_wdata),
        .wb_cyc          (wb_cyc),
        .wb_stb          (wb_stb),
        .wb_we           (wb_we),
        .wb_sel          (wb_sel),
        .wb_adr          (wb_adr),
        .wb_dat_o        (wb_dat_o),
        .wb_dat_i        (wb_dat_i),
        .wb_ack          (wb_ack),
        .mem_busy        (mem_busy),
        .mem_rdata       (mem_rdata),
        .mem_rdata_valid (mem_rdata_valid)
    );

endmodule

// File: testbench/ctrl_path_properties.sv
`include "rv32_ctrl_consts.svh"

module ctrl_path_properties (
    input logic                            clk,
    input logic                            rst,
    input rv32_ctrl_pkg::instr_word_u      instr,
    input logic                            instr_valid,
    input logic                            redirect,
    input logic [31:0]                     mem_addr,
    input logic [31:0]                     mem_wdata,
    input logic                            stall,
    input rv32_ctrl_pkg::cmpmux_sel_t      cmpmux_sel,
    input rv32_ctrl_pkg::alumux1_sel_t     alumux1_sel,
    input rv32_ctrl_pkg::alumux2_sel_t     alumux2_sel,
    input rv32_ctrl_pkg::alu_op_t          alu_op,
    input rv32_ctrl_pkg::branch_funct3_t   cmp_op,
    input rv32_ctrl_pkg::pcmux_sel_t       pcmux_sel,
    input rv32_ctrl_pkg::regfilemux_sel_t  regfilemux_sel,
    input logic                            regfile_wb,
    input logic [`RV_REG_W-1:0]            regfile_rd,
    input logic                            wb_cyc,
    input logic                            wb_stb,
    input logic                            wb_we,
    input logic [`RV_BE_W-1:0]             wb_sel,
    input logic [31:0]                     wb_adr,
    input logic [31:0]                     wb_dat_o,
    input logic                            wb_ack,
    input logic [31:0]                     mem_rdata,
    input logic                            mem_rdata_valid
);
    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        logic                       wb;
        logic [`RV_REG_W-1:0]       rd;
        rv32_ctrl_pkg::pcmux_sel_t  pc;
        logic                       rd_en;
        logic                       wr_en;
        logic [`RV_BE_W-1:0]        be;
    } exp_t;

    localparam exp_t EXP_BUBBLE = '0;

    exp_t        pipe_q [0:3];
    logic        acked;
    logic [31:0] exp_rdata;
    int unsigned fail_count = 0;

    // Expected fields straight from the RV32I encoding
    function automatic exp_t expected_ctrl(input rv32_ctrl_pkg::instr_word_u w);
        exp_t       e;
        logic [2:0] f3;
        e = EXP_BUBBLE;
        f3 = w.r.funct3;
        case (w.r.opcode)
            `RV_OP_JAL, `RV_OP_BR: e.pc = rv32_ctrl_pkg::pcmux_alu_out;
            `RV_OP_JALR:           e.pc = rv32_ctrl_pkg::pcmux_alu_mod2;
            `RV_OP_LOAD:           e.rd_en = (f3 != 3'b011) && (f3[2:1] != 2'b11);
            `RV_OP_STORE:          e.wr_en = !f3[2] && (f3 != 3'b011);
            default: ;
        endcase
        e.wb = e.rd_en || (w.r.opcode inside {`RV_OP_LUI, `RV_OP_AUIPC, `RV_OP_JAL,
                                              `RV_OP_JALR, `RV_OP_IMM, `RV_OP_REG});
        if (e.wb) begin
            e.rd = w.r.rd;
        end
        if (e.rd_en || e.wr_en) begin
            e.be = f3[1] ? 4'b1111 : (f3[0] ? 4'b0011 : 4'b0001);
        end
        return e;
    endfunction

    // Index 0 is IF/ID, index 3 is MEM/WB
    always @(posedge clk) begin
        if (rst) begin
            pipe_q <= '{default: EXP_BUBBLE};
            acked  <= 1'b0;
        end else begin
            if (wb_cyc && wb_ack) begin
                acked     <= 1'b1;
                exp_rdata <= mem_addr ^ 32'hA5A5_5A5A;
            end
            if (!stall) begin
                pipe_q[0] <= redirect ? EXP_BUBBLE : expected_ctrl(instr);
                pipe_q[1] <= redirect ? EXP_BUBBLE : pipe_q[0];
                pipe_q[2] <= pipe_q[1];
                pipe_q[3] <= pipe_q[2];
                acked     <= 1'b0;
            end
        end
    end

    mem_wb_check: assert property (@(posedge clk) disable iff (rst)
        regfile_wb == pipe_q[3].wb && regfile_rd == pipe_q[3].rd)
    else begin
        $error("Fail mem_wb_check expected wb=%0b rd=%0d actual wb=%0b rd=%0d",
               $sampled(pipe_q[3].wb), $sampled(pipe_q[3].rd),
               $sampled(regfile_wb), $sampled(regfile_rd));
        fail_count++;
    end

    pcmux_check: assert property (@(posedge clk) disable iff (rst)
        pcmux_sel == pipe_q[1].pc)
    else begin
        $error("Fail pcmux_check expected %0d actual %0d",
               $sampled(pipe_q[1].pc), $sampled(pcmux_sel));
        fail_count++;
    end

    stall_hold: assert property (@(posedge clk) disable iff (rst)
        stall |=> $stable(cmpmux_sel) && $stable(alumux1_sel) && $stable(alumux2_sel)
                  && $stable(alu_op) && $stable(cmp_op) && $stable(pcmux_sel)
                  && $stable(regfilemux_sel) && $stable(regfile_wb) && $stable(regfile_rd))
    else begin
        $error("Stage outputs changed while the pipeline was stalled");
        fail_count++;
    end

    stall_rule: assert property (@(posedge clk) disable iff (rst)
        stall == (!instr_valid
                  || ((pipe_q[2].rd_en || pipe_q[2].wr_en) && !acked && !wb_ack)))
    else begin
        $error("Fail stall_rule expected %0b actual %0b",
               $sampled(!instr_valid
                        || ((pipe_q[2].rd_en || pipe_q[2].wr_en) && !acked && !wb_ack)),
               $sampled(stall));
        fail_count++;
    end

    stb_needs_cyc: assert property (@(posedge clk) disable iff (rst) wb_stb |-> wb_cyc)
    else begin
        $error("Strobe was high without an active bus cycle");
        fail_count++;
    end

    cyc_check: assert property (@(posedge clk) disable iff (rst)
        wb_cyc == ((pipe_q[2].rd_en || pipe_q[2].wr_en) && !acked))
    else begin
        $error("Fail cyc_check expected %0b actual %0b",
               $sampled((pipe_q[2].rd_en || pipe_q[2].wr_en) && !acked), $sampled(wb_cyc));
        fail_count++;
    end

    bus_fields: assert property (@(posedge clk) disable iff (rst)
        wb_cyc |-> wb_we == pipe_q[2].wr_en && wb_sel == pipe_q[2].be)
    else begin
        $error("Fail bus_fields expected we=%0b sel=%b actual we=%0b sel=%b",
               $sampled(pipe_q[2].wr_en), $sampled(pipe_q[2].be),
               $sampled(wb_we), $sampled(wb_sel));
        fail_count++;
    end

    bus_data: assert property (@(posedge clk) disable iff (rst)
        wb_cyc |-> wb_adr == mem_addr && (!wb_we || wb_dat_o == mem_wdata))
    else begin
        $error("Fail bus_data expected adr=%h dat=%h actual adr=%h dat=%h",
               $sampled(mem_addr), $sampled(mem_wdata),
               $sampled(wb_adr), $sampled(wb_dat_o));
        fail_count++;
    end

    bus_hold: assert property (@(posedge clk) disable iff (rst)
        wb_cyc && !wb_ack |=> wb_cyc && wb_stb && $stable(wb_adr) && $stable(wb_sel)
                              && $stable(wb_we) && $stable(wb_dat_o))
    else begin
        $error("Bus cycle dropped or changed before the acknowledge");
        fail_count++;
    end

    drop_after_ack: assert property (@(posedge clk) disable iff (rst)
        wb_cyc && wb_ack |=> !wb_cyc)
    else begin
        $error("Bus cycle stayed active after the acknowledge");
        fail_count++;
    end

    rdata_pulse: assert property (@(posedge clk) disable iff (rst)
        mem_rdata_valid == $past(wb_ack && pipe_q[2].rd_en && !acked))
    else begin
        $error("Read data valid did not follow the read acknowledge");
        fail_count++;
    end

    rdata_check: assert property (@(posedge clk) disable iff (rst)
        mem_rdata_valid |-> mem_rdata == exp_rdata)
    else begin
        $error("Fail rdata_check expected %h actual %h",
               $sampled(exp_rdata), $sampled(mem_rdata));
        fail_count++;
    end

endmodule

// File: testbench/ctrl_path_tb.sv
`include "rv32_ctrl_consts.svh"

module ctrl_path_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int  NUM_INSTR        = 400;
    localparam int  CYCLES_PER_INSTR = 8;
    localparam int  PIPE_DEPTH       = 4;
    localparam time CLK_PERIOD       = 40ns;

    logic                           clk;
    logic                           rst;
    rv32_ctrl_pkg::instr_word_u     instr;
    logic                           instr_valid;
    logic                           redirect;
    logic [31:0]                    mem_addr;
    logic [31:0]                    mem_wdata;
    rv32_ctrl_pkg::cmpmux_sel_t     cmpmux_sel;
    rv32_ctrl_pkg::alumux1_sel_t    alumux1_sel;
    rv32_ctrl_pkg::alumux2_sel_t    alumux2_sel;
    rv32_ctrl_pkg::alu_op_t         alu_op;
    rv32_ctrl_pkg::branch_funct3_t  cmp_op;
    rv32_ctrl_pkg::pcmux_sel_t      pcmux_sel;
    rv32_ctrl_pkg::regfilemux_sel_t regfilemux_sel;
    logic                           regfile_wb;
    logic [`RV_REG_W-1:0]           regfile_rd;
    logic                           stall;
    logic [31:0]                    mem_rdata;
    logic                           mem_rdata_valid;
    logic                           wb_cyc;
    logic                           wb_stb;
    logic                           wb_we;
    logic [`RV_BE_W-1:0]            wb_sel;
    logic [31:0]                    wb_adr;
    logic [31:0]                    wb_dat_o;
    logic [31:0]                    wb_dat_i;
    logic                           wb_ack;

    logic advanced;
    logic last_mem;
    int   accepted;
    int   wait_left;

    bind ctrl_path_top ctrl_path_properties props (.*);

    ctrl_path_top DUT (.*);

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // Random word with a chosen opcode, pick 10 keeps random opcode bits
    function automatic logic [31:0] random_instr(input logic no_mem);
        logic [31:0] word;
        int unsigned pick;
        word = $urandom;
        pick = $urandom_range(10, 0);
        // Keep two data accesses apart in EX/MEM
        if (no_mem && (pick == 5 || pick == 6)) begin
            pick = 7;
        end
        case (pick)
            0: word[6:0] = `RV_OP_LUI;
            1: word[6:0] = `RV_OP_AUIPC;
            2: word[6:0] = `RV_OP_JAL;
            3: word[6:0] = `RV_OP_JALR;
            4: word[6:0] = `RV_OP_BR;
            5: word[6:0] = `RV_OP_LOAD;
            6: word[6:0] = `RV_OP_STORE;
            7: word[6:0] = `RV_OP_IMM;
            8: word[6:0] = `RV_OP_REG;
            9: word[6:0] = 7'b1110011;
            default: ;
        endcase
        return word;
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            advanced <= 1'b0;
            last_mem <= 1'b0;
            accepted <= 0;
        end else begin
            advanced <= !stall;
            if (!stall) begin
                accepted <= accepted + 1;
                last_mem <= instr.r.opcode inside {`RV_OP_LOAD, `RV_OP_STORE};
            end
        end
    end

    // Slave reads back address XOR a fixed pattern
    assign wb_dat_i = wb_ack ? (wb_adr ^ 32'hA5A5_5A5A) : 32'h0;

    always @(negedge clk) begin
        if (rst || !wb_cyc || wb_ack) begin
            wb_ack    = 1'b0;
            wait_left = -1;
        end else begin
            if (wait_left < 0) begin
                wait_left = $urandom_range(3, 0);
            end
            if (wait_left == 0) begin
                wb_ack = 1'b1;
            end
            wait_left = wait_left - 1;
        end
    end

    always @(negedge clk) begin
        if (DUT.props.fail_count != 0) begin
            $display("Finished with errors");
            $fatal(1, "An assertion on the control path failed");
        end
    end

    initial begin
        #(NUM_INSTR * CYCLES_PER_INSTR * CLK_PERIOD);
        $display("Finished with errors");
        $fatal(1, "Timeout: the instruction stream did not drain in time");
    end

    initial begin
        void'($urandom(58));
        rst         = 1'b1;
        instr       = '0;
        instr_valid = 1'b0;
        redirect    = 1'b0;
        mem_addr    = '0;
        mem_wdata   = '0;
        wb_ack      = 1'b0;
        wait_left   = -1;
        repeat (3) @(negedge clk);
        rst = 1'b0;

        while (accepted < NUM_INSTR + PIPE_DEPTH) begin
            @(negedge clk);
            if (advanced) begin
                mem_addr  = $urandom;
                mem_wdata = $urandom;
            end
            // A word that was offered but not taken stays on the inputs
            if (!(instr_valid && !advanced)) begin
                instr_valid = ($urandom_range(7, 0) != 0);
                instr       = random_instr(last_mem);
            end
            if (!(redirect && !advanced)) begin
                redirect = ($urandom_range(11, 0) == 0);
            end
        end

        @(posedge clk);
        #1;
        if (DUT.props.fail_count == 0) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            $display("Finished with errors");
            $fatal(1, "Assertion failures were reported during the run");
        end
    end

endmodule

// File: project.f
+incdir+include
rtl/rv32_ctrl_pkg.sv
rtl/ctrl_decoder.sv
rtl/ctrl_word_pipe.sv
rtl/dmem_wb_master.sv
rtl/ctrl_path_top.sv
testbench/ctrl_path_properties.sv
testbench/ctrl_path_tb.sv
